//--- rtl/icache_params.svh
`ifndef ICACHE_PARAMS_SVH
`define ICACHE_PARAMS_SVH

// cache geometry, 4 KB direct mapped
`define ICACHE_IDX_W 6   // 64 lines
`define ICACHE_OFF_W 6   // 64 bytes per line
`define ICACHE_TAG_W 20  // 32 - 6 - 6
`define ICACHE_LINES 64

// refill burst, 64-bit beats
`define ICACHE_BEATS 8

// uncached region after reset
`define ICACHE_UNC_BASE_RST 32'h1000_0000
`define ICACHE_UNC_MASK_RST 32'hf000_0000

`endif

//--- rtl/icache_pkg.sv
`default_nettype none

`include "icache_params.svh"

package icache_pkg;

  // fetch address split, msb first
  typedef struct packed {
    logic [`ICACHE_TAG_W-1:0] tag;
    logic [`ICACHE_IDX_W-1:0] index;
    logic [`ICACHE_OFF_W-1:0] offset;  // byte within line
  } icache_addr_t;

  // request from the fetch stage
  typedef struct packed {
    logic         valid;
    icache_addr_t addr;
  } fetch_req_t;

  // read request toward memory
  typedef struct packed {
    logic        valid;
    logic [31:0] addr;
    logic [3:0]  size;  // bytes per beat
    logic [7:0]  len;   // beats - 1
  } mem_req_t;

  // region register write
  typedef struct packed {
    logic        we;
    logic        sel;  // 0 base, 1 mask
    logic [31:0] data;
  } cfg_wr_t;

endpackage

`default_nettype wire

//--- rtl/icache_region_cfg.sv
`default_nettype none

`include "icache_params.svh"

module icache_region_cfg (
  input  wire                  clk,
  input  wire                  rst,
  input  icache_pkg::cfg_wr_t  cfg_wr_i,
  input  wire [31:0]           addr_i,
  output logic                 uncached_o
);

  logic [31:0] base_q;
  logic [31:0] mask_q;

  // base/mask registers, new value visible next cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      base_q <= `ICACHE_UNC_BASE_RST;
      mask_q <= `ICACHE_UNC_MASK_RST;
    end else if (cfg_wr_i.we) begin
      if (cfg_wr_i.sel) begin
        mask_q <= cfg_wr_i.data;
      end else begin
        base_q <= cfg_wr_i.data;
      end
    end
  end

  // masked bits of address must match the base
  always_comb begin
    uncached_o = ((addr_i ^ base_q) & mask_q) == 32'h0;
  end

  // a base bit outside the mask would make the region test
  // ignore that bit silently; software must keep them aligned
  a_base_in_mask: assert property (
    @(posedge clk) disable iff (rst)
    cfg_wr_i.we |=> ((base_q & ~mask_q) == 32'h0)
  ) else $error("region base has bits outside mask");

endmodule

`default_nettype wire

//--- rtl/icache_tag_array.sv
`default_nettype none

`include "icache_params.svh"

module icache_tag_array (
  input  wire                       clk,
  input  wire                       rst,
  input  icache_pkg::icache_addr_t  addr_i,
  input  wire                       tag_we_i,
  output logic                      hit_o
);

  logic [`ICACHE_LINES-1:0] valid_q;
  logic [`ICACHE_TAG_W-1:0] tag_q [`ICACHE_LINES];

  logic [`ICACHE_IDX_W-1:0] idx;
  logic [`ICACHE_TAG_W-1:0] tag;

  assign idx = addr_i.index;
  assign tag = addr_i.tag;

  // valid bits cleared on reset
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
    end else if (tag_we_i) begin
      valid_q[idx] <= 1'b1;  // line now holds the refilled tag
    end
  end

  // tag store
  always_ff @(posedge clk) begin
    if (tag_we_i) begin
      tag_q[idx] <= tag;
    end
  end

  // hit straight from the registered arrays
  always_comb begin
    hit_o = valid_q[idx] && (tag_q[idx] == tag);
  end

endmodule

`default_nettype wire

//--- rtl/icache_data_array.sv
`default_nettype none

`include "icache_params.svh"

module icache_data_array (
  input  wire                       clk,
  input  icache_pkg::icache_addr_t  addr_i,
  input  wire [5:0]                 rd_off_i,  // offset of last cycle's lookup
  input  wire                       wr_en_i,
  input  wire [2:0]                 beat_i,
  input  wire [63:0]                wdata_i,
  output logic [63:0]               rdata_o
);

  localparam int BANKS = 4;

  // four 128 x 64 banks, two beats per bank entry
  logic [127:0] mem_q [BANKS][`ICACHE_LINES];
  logic [127:0] rd_q  [BANKS];

  logic [`ICACHE_IDX_W-1:0] idx;
  logic [1:0]               wr_bank;
  logic [127:0]             wr_mask;
  logic [127:0]             wr_data;

  logic [127:0] sel_line;
  logic [63:0]  sel_half;
  logic [31:0]  sel_word;

  assign idx     = addr_i.index;
  assign wr_bank = beat_i[2:1];  // beat n goes to bank n/2

  // odd beats land in the upper half
  always_comb begin
    wr_mask = beat_i[0] ? {{64{1'b1}}, 64'h0} : {64'h0, {64{1'b1}}};
    wr_data = {wdata_i, wdata_i} & wr_mask;
  end

  always_ff @(posedge clk) begin
    if (wr_en_i) begin
      mem_q[wr_bank][idx] <= (mem_q[wr_bank][idx] & ~wr_mask) | wr_data;
    end
    for (int b = 0; b < BANKS; b++) begin
      rd_q[b] <= mem_q[b][idx];  // all banks read every cycle
    end
  end

  // word select from the registered offset
  always_comb begin
    sel_line = rd_q[rd_off_i[5:4]];
    sel_half = rd_off_i[3] ? sel_line[127:64] : sel_line[63:0];
    sel_word = rd_off_i[2] ? sel_half[63:32] : sel_half[31:0];
    rdata_o  = {32'h0, sel_word};  // zero-extended instruction
  end

  // burst ends with beat 7, then tag write and replayed read;
  // no beat may fall into those two cycles
  a_no_wr_on_replay: assert property (
    @(posedge clk)
    (wr_en_i && (beat_i == 3'd7)) |=> !wr_en_i [*2]
  ) else $error("data write overlaps replayed read");

endmodule

`default_nettype wire

//--- rtl/icache_ctrl.sv
`default_nettype none

`include "icache_params.svh"

module icache_ctrl (
  input  wire                     clk,
  input  wire                     rst,
  input  icache_pkg::fetch_req_t  fetch_req_i,
  input  wire                     hit_i,
  input  wire                     uncached_i,
  output logic                    tag_we_o,
  output logic                    data_we_o,
  output logic [2:0]              beat_o,
  output logic [5:0]              rd_off_o,
  output icache_pkg::mem_req_t    mem_req_o,
  input  wire                     mem_ready_i,
  input  wire [63:0]              mem_rdata_i,
  input  wire [63:0]              rdata_array_i,
  output logic [63:0]             rdata_o,
  output logic                    rdata_valid_o
);

  localparam logic [7:0] LEN_FILL = 8'(`ICACHE_BEATS - 1);

  typedef enum logic [1:0] {
    ST_RST,
    ST_IDLE,
    ST_REFILL,
    ST_UNC
  } state_e;

  state_e      state_q;
  logic        ready_q;    // one-cycle data valid
  logic        tag_we_q;
  logic        unc_sel_q;  // last answer came from memory
  logic        mem_valid_q;
  logic [2:0]  beat_q;

  logic [31:0] mem_addr_q;
  logic [3:0]  mem_size_q;
  logic [7:0]  mem_len_q;
  logic [5:0]  rd_off_q;
  logic [63:0] unc_q;

  logic mem_hs;
  logic last_beat;
  logic accept;
  logic issue_unc;
  logic issue_fill;
  logic unc_done;

  assign mem_hs    = mem_valid_q && mem_ready_i;
  assign last_beat = mem_hs && (beat_q == mem_len_q[2:0]);

  // skip the cycle that answers the held request, and the tag write cycle
  assign accept     = (state_q == ST_IDLE) && fetch_req_i.valid && !tag_we_q && !ready_q;
  assign issue_unc  = accept && uncached_i;
  assign issue_fill = accept && !uncached_i && !hit_i;
  assign unc_done   = (state_q == ST_UNC) && mem_hs;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q     <= ST_RST;
      ready_q     <= 1'b0;
      tag_we_q    <= 1'b0;
      unc_sel_q   <= 1'b0;
      mem_valid_q <= 1'b0;
      beat_q      <= 3'd0;
    end else begin
      case (state_q)
        ST_RST: state_q <= ST_IDLE;
        ST_IDLE: begin
          ready_q  <= 1'b0;
          tag_we_q <= 1'b0;
          beat_q   <= 3'd0;
          if (issue_unc) begin
            mem_valid_q <= 1'b1;
            state_q     <= ST_UNC;
          end else if (issue_fill) begin
            mem_valid_q <= 1'b1;
            state_q     <= ST_REFILL;
          end else if (accept) begin  // hit
            ready_q   <= 1'b1;
            unc_sel_q <= 1'b0;
          end
        end
        ST_REFILL: begin
          if (last_beat) begin
            mem_valid_q <= 1'b0;
            tag_we_q    <= 1'b1;  // lookup replays after this
            state_q     <= ST_IDLE;
          end else if (mem_hs) begin
            beat_q <= beat_q + 3'd1;  // completed beats only
          end
        end
        ST_UNC: begin
          if (unc_done) begin
            mem_valid_q <= 1'b0;
            ready_q     <= 1'b1;
            unc_sel_q   <= 1'b1;
            state_q     <= ST_IDLE;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // request payload and returned word
  always_ff @(posedge clk) begin
    if (state_q == ST_IDLE) begin
      rd_off_q <= fetch_req_i.addr.offset;
    end
    if (issue_unc) begin
      mem_addr_q <= {fetch_req_i.addr[31:2], 2'b00};  // word address
      mem_size_q <= 4'd4;
      mem_len_q  <= 8'd0;
    end else if (issue_fill) begin
      mem_addr_q <= {fetch_req_i.addr.tag, fetch_req_i.addr.index, {`ICACHE_OFF_W{1'b0}}};
      mem_size_q <= 4'd8;
      mem_len_q  <= LEN_FILL;
    end
    if (unc_done) begin
      unc_q <= mem_addr_q[2] ? {32'h0, mem_rdata_i[63:32]} : {32'h0, mem_rdata_i[31:0]};
    end
  end

  always_comb begin
    mem_req_o.valid = mem_valid_q;
    mem_req_o.addr  = mem_addr_q;
    mem_req_o.size  = mem_size_q;
    mem_req_o.len   = mem_len_q;
  end

  assign tag_we_o      = tag_we_q;
  assign data_we_o     = (state_q == ST_REFILL) && mem_hs;
  assign beat_o        = beat_q;
  assign rd_off_o      = rd_off_q;
  assign rdata_o       = unc_sel_q ? unc_q : rdata_array_i;
  assign rdata_valid_o = ready_q;

  a_req_stable: assert property (
    @(posedge clk) disable iff (rst)
    (mem_valid_q && !last_beat) |=>
      mem_valid_q && $stable(mem_addr_q) && $stable(mem_size_q) && $stable(mem_len_q)
  ) else $error("memory request changed while valid");

  a_valid_drop: assert property (
    @(posedge clk) disable iff (rst)
    last_beat |=> !mem_valid_q
  ) else $error("memory valid held after last beat");

endmodule

`default_nettype wire

//--- rtl/icache_top.sv
`default_nettype none

module icache_top (
  input  wire                     clk,
  input  wire                     rst,
  input  icache_pkg::fetch_req_t  fetch_req_i,
  output logic [63:0]             rdata_o,
  output logic                    rdata_valid_o,
  output icache_pkg::mem_req_t    mem_req_o,
  input  wire                     mem_ready_i,
  input  wire [63:0]              mem_rdata_i,
  input  icache_pkg::cfg_wr_t     cfg_wr_i
);

  logic        uncached;
  logic        hit;
  logic        tag_we;
  logic        data_we;
  logic [2:0]  beat;
  logic [5:0]  rd_off;
  logic [63:0] rdata_array;

  icache_ctrl i_icache_ctrl (
    .clk           (clk),
    .rst           (rst),
    .fetch_req_i   (fetch_req_i),
    .hit_i         (hit),
    .uncached_i    (uncached),
    .tag_we_o      (tag_we),
    .data_we_o     (data_we),
    .beat_o        (beat),
    .rd_off_o      (rd_off),
    .mem_req_o     (mem_req_o),
    .mem_ready_i   (mem_ready_i),
    .mem_rdata_i   (mem_rdata_i),
    .rdata_array_i (rdata_array),
    .rdata_o       (rdata_o),
    .rdata_valid_o (rdata_valid_o)
  );

  icache_region_cfg i_icache_region_cfg (
    .clk        (clk),
    .rst        (rst),
    .cfg_wr_i   (cfg_wr_i),
    .addr_i     (fetch_req_i.addr),  // whole 32-bit address
    .uncached_o (uncached)
  );

  icache_tag_array i_icache_tag_array (
    .clk      (clk),
    .rst      (rst),
    .addr_i   (fetch_req_i.addr),
    .tag_we_i (tag_we),
    .hit_o    (hit)
  );

  // refill beats come straight off the memory bus
  icache_data_array i_icache_data_array (
    .clk      (clk),
    .addr_i   (fetch_req_i.addr),
    .rd_off_i (rd_off),
    .wr_en_i  (data_we),
    .beat_i   (beat),
    .wdata_i  (mem_rdata_i),
    .rdata_o  (rdata_array)
  );

endmodule

`default_nettype wire

//--- sim/mem_model.sv
`default_nettype none

module mem_model (
  input  wire                   clk,
  input  wire                   rst,
  input  icache_pkg::mem_req_t  mem_req_i,
  output logic                  mem_ready_o,
  output logic [63:0]           mem_rdata_o,
  output logic [31:0]           fill_cnt_o,
  output logic [31:0]           unc_cnt_o,
  output logic [31:0]           bad_cnt_o
);
  timeunit 1ns;
  timeprecision 1ps;

  logic        ready_q    = 1'b0;
  logic [63:0] rdata_q    = '0;
  logic [31:0] fill_cnt_q = '0;  // len 7 bursts
  logic [31:0] unc_cnt_q  = '0;  // len 0 reads
  logic [31:0] bad_cnt_q  = '0;

  // transfer in progress
  logic        busy     = 1'b0;
  logic [31:0] cur_addr = '0;
  logic [7:0]  cur_len  = '0;
  logic [8:0]  beat     = '0;

  // every aligned word holds its own address, scrambled
  function automatic logic [31:0] word_at(input logic [31:0] addr);
    return addr ^ 32'hc3a5_0f1e;
  endfunction

  function automatic logic [63:0] beat_data(input logic [31:0] addr, input logic [8:0] beat_n);
    logic [31:0] dw;
    dw = {addr[31:3], 3'b000} + {20'h0, beat_n, 3'b000};
    return {word_at(dw + 32'd4), word_at(dw)};
  endfunction

  always @(posedge clk) begin
    if (rst) begin
      busy       = 1'b0;
      beat       = '0;
      ready_q    <= 1'b0;
      fill_cnt_q <= '0;
      unc_cnt_q  <= '0;
      bad_cnt_q  <= '0;
    end else begin
      if (mem_req_i.valid && !busy) begin  // new request
        busy     = 1'b1;
        beat     = '0;
        cur_addr = mem_req_i.addr;
        cur_len  = mem_req_i.len;
        if (mem_req_i.len == 8'd7) begin
          fill_cnt_q <= fill_cnt_q + 32'd1;
          if (mem_req_i.addr[5:0] != 6'd0 || mem_req_i.size != 4'd8) begin
            bad_cnt_q <= bad_cnt_q + 32'd1;
          end
        end else if (mem_req_i.len == 8'd0) begin
          unc_cnt_q <= unc_cnt_q + 32'd1;
          if (mem_req_i.addr[1:0] != 2'd0 || mem_req_i.size != 4'd4) begin
            bad_cnt_q <= bad_cnt_q + 32'd1;
          end
        end else begin
          bad_cnt_q <= bad_cnt_q + 32'd1;
        end
      end else if (busy && mem_req_i.valid) begin
        if (mem_req_i.addr != cur_addr) begin
          bad_cnt_q <= bad_cnt_q + 32'd1;  // request moved mid-transfer
        end
        if (ready_q) begin
          beat = beat + 9'd1;
          if (beat > {1'b0, cur_len}) begin
            busy = 1'b0;
          end
        end
      end
      if (busy) begin
        ready_q <= ($urandom % 4) != 0;  // stall about one cycle in four
        rdata_q <= beat_data(cur_addr, beat);
      end else begin
        ready_q <= 1'b0;
      end
    end
  end

  assign mem_ready_o = ready_q;
  assign mem_rdata_o = rdata_q;
  assign fill_cnt_o  = fill_cnt_q;
  assign unc_cnt_o   = unc_cnt_q;
  assign bad_cnt_o   = bad_cnt_q;

endmodule

`default_nettype wire

//--- sim/tb_icache.sv
`default_nettype none

module tb_icache;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_HALF   = 4;
  localparam int RST_CYCLES = 5;
  localparam int WAIT_LIMIT = 200;

  // one stimulus row
  typedef struct packed {
    logic [2:0]  group;  // behavior under test
    logic [31:0] addr;
    logic        cfg_we;
    logic        cfg_sel;
    logic [31:0] cfg_data;
    logic [3:0]  fills;  // expected len 7 bursts
    logic [3:0]  uncs;   // expected len 0 reads
  } entry_t;

  logic                   clk;
  logic                   rst;
  icache_pkg::fetch_req_t fetch_req;
  icache_pkg::cfg_wr_t    cfg_wr;
  icache_pkg::mem_req_t   mem_req;
  logic                   mem_ready;
  logic [63:0]            mem_rdata;
  logic [63:0]            rdata;
  logic                   rdata_valid;
  logic [31:0]            fill_cnt;
  logic [31:0]            unc_cnt;
  logic [31:0]            bad_cnt;

  entry_t      tests[$];
  int          errors;
  int          passed;
  int          failed;
  logic        timed_out;
  logic [31:0] last_fills;
  logic [31:0] last_uncs;

  icache_top i_icache_top (
    .clk           (clk),
    .rst           (rst),
    .fetch_req_i   (fetch_req),
    .rdata_o       (rdata),
    .rdata_valid_o (rdata_valid),
    .mem_req_o     (mem_req),
    .mem_ready_i   (mem_ready),
    .mem_rdata_i   (mem_rdata),
    .cfg_wr_i      (cfg_wr)
  );

  mem_model i_mem_model (
    .clk         (clk),
    .rst         (rst),
    .mem_req_i   (mem_req),
    .mem_ready_o (mem_ready),
    .mem_rdata_o (mem_rdata),
    .fill_cnt_o  (fill_cnt),
    .unc_cnt_o   (unc_cnt),
    .bad_cnt_o   (bad_cnt)
  );

  initial begin
    clk = 1'b0;
    forever #CLK_HALF clk = ~clk;
  end

  // instruction word at addr, zero-extended
  function automatic logic [63:0] expected_rdata(input logic [31:0] addr);
    logic [31:0] w;
    w = {addr[31:2], 2'b00};
    return {32'h0, w ^ 32'hc3a5_0f1e};
  endfunction

  task automatic add_fetch(input int grp, input logic [31:0] addr, input int fills,
                           input int uncs);
    entry_t e;
    e       = '0;
    e.group = 3'(grp);
    e.addr  = addr;
    e.fills = 4'(fills);
    e.uncs  = 4'(uncs);
    tests.push_back(e);
  endtask

  task automatic load_table();
    add_fetch(1, 32'h0000_2040, 1, 0);
    add_fetch(2, 32'h0000_2044, 0, 0);  // bank 0 low half
    add_fetch(2, 32'h0000_2048, 0, 0);
    add_fetch(2, 32'h0000_2054, 0, 0);
    add_fetch(2, 32'h0000_2058, 0, 0);
    add_fetch(2, 32'h0000_2060, 0, 0);
    add_fetch(2, 32'h0000_206c, 0, 0);
    add_fetch(2, 32'h0000_2074, 0, 0);
    add_fetch(2, 32'h0000_2078, 0, 0);  // bank 3 high half
    add_fetch(2, 32'h0000_2040, 0, 0);
    add_fetch(3, 32'h0000_3040, 1, 0);  // same index, new tag
    add_fetch(3, 32'h0000_307c, 0, 0);
    add_fetch(3, 32'h2000_0080, 1, 0);
    add_fetch(3, 32'h0000_2040, 1, 0);
    add_fetch(3, 32'h0000_2060, 0, 0);
    add_fetch(4, 32'h1000_0100, 0, 1);
    add_fetch(4, 32'h1000_0104, 0, 1);
    add_fetch(4, 32'h1000_0100, 0, 1);
    add_fetch(4, 32'h1000_0104, 0, 1);
    add_fetch(5, 32'h1000_0100, 1, 0);
    tests[tests.size() - 1].cfg_we   = 1'b1;  // move region base
    tests[tests.size() - 1].cfg_data = 32'h2000_0000;
    add_fetch(5, 32'h1000_0104, 0, 0);
    add_fetch(5, 32'h2000_0080, 0, 1);  // line still valid, bypassed
    add_fetch(5, 32'h2000_0084, 0, 1);
    add_fetch(5, 32'h1000_013c, 0, 0);
    add_fetch(6, 32'h0000_4fc0, 1, 0);  // last index
    add_fetch(6, 32'h0000_4ff8, 0, 0);
  endtask

  task automatic wait_rdata(output int cycles, output logic late);
    cycles = 0;
    late   = 1'b0;
    @(negedge clk);
    while (!rdata_valid && !late) begin
      cycles++;
      if (cycles > WAIT_LIMIT) begin
        late = 1'b1;
      end else begin
        @(negedge clk);
      end
    end
  endtask

  task automatic run_entry(input int n, input entry_t e);
    logic [63:0] exp_data;
    int          lat;
    int          err0;
    logic        late;
    err0     = errors;
    exp_data = expected_rdata(e.addr);
    if (e.cfg_we) begin
      @(posedge clk);
      cfg_wr <= '{we: 1'b1, sel: e.cfg_sel, data: e.cfg_data};
    end
    @(posedge clk);
    cfg_wr.we <= 1'b0;
    fetch_req <= '{valid: 1'b1, addr: icache_pkg::icache_addr_t'(e.addr)};
    wait_rdata(lat, late);
    if (late) begin
      $display("Timeout at %0t: test %0d got no rdata_valid_o within %0d cycles",
               $time, n, WAIT_LIMIT);
      timed_out = 1'b1;
      errors++;
    end else begin
      assert (rdata == exp_data) else begin
        $display("Mismatch at %0t: test %0d addr %h rdata %h expected %h",
                 $time, n, e.addr, rdata, exp_data);
        errors++;
      end
      assert (fill_cnt - last_fills == 32'(e.fills)) else begin
        $display("Mismatch at %0t: test %0d refills %0d expected %0d",
                 $time, n, fill_cnt - last_fills, e.fills);
        errors++;
      end
      assert (unc_cnt - last_uncs == 32'(e.uncs)) else begin
        $display("Mismatch at %0t: test %0d uncached reads %0d expected %0d",
                 $time, n, unc_cnt - last_uncs, e.uncs);
        errors++;
      end
      assert (bad_cnt == 32'd0) else begin
        $display("Test %0d: memory saw a request with wrong size, length or alignment", n);
        errors++;
      end
      if (e.fills == 4'd0 && e.uncs == 4'd0) begin
        assert (lat == 1) else begin
          $display("Mismatch at %0t: test %0d hit latency %0d expected 1", $time, n, lat);
          errors++;
        end
      end
      if (e.fills != 4'd0) begin
        assert (lat >= 10) else begin
          $display("Mismatch at %0t: test %0d refill latency %0d below 10", $time, n, lat);
          errors++;
        end
      end
      last_fills = fill_cnt;
      last_uncs  = unc_cnt;
      @(posedge clk);
      fetch_req.valid <= 1'b0;
      @(negedge clk);
      assert (!rdata_valid) else begin
        $display("Test %0d: rdata_valid_o stayed high for more than one cycle", n);
        errors++;
      end
    end
    if (errors == err0) passed++;
    else failed++;
    $display("test %0d behavior %0d addr %h latency %0d: %s", n, e.group, e.addr, lat,
             (errors == err0) ? "ok" : "bad");
  endtask

  initial begin
    void'($urandom(32'hfa54_e8bd));
    rst       = 1'b1;
    fetch_req = '0;
    cfg_wr    = '0;
    errors    = 0;
    passed    = 0;
    failed    = 0;
    timed_out = 1'b0;
    load_table();
    repeat (RST_CYCLES) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    assert (!rdata_valid && !mem_req.valid) else begin
      $display("Mismatch at %0t: after reset rdata_valid_o %b mem_req valid %b",
               $time, rdata_valid, mem_req.valid);
      errors++;
    end
    last_fills = fill_cnt;
    last_uncs  = unc_cnt;
    foreach (tests[i]) begin
      if (!timed_out) begin
        run_entry(i, tests[i]);
      end
    end
    $display("tests %0d, passed %0d, failed %0d, errors %0d", tests.size(), passed, failed,
             errors);
    if (errors == 0 && !timed_out) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- build.f
+incdir+rtl
rtl/icache_pkg.sv
rtl/icache_region_cfg.sv
rtl/icache_tag_array.sv
rtl/icache_data_array.sv
rtl/icache_ctrl.sv
rtl/icache_top.sv
sim/mem_model.sv
sim/tb_icache.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the icache testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -j 0 \
  --top-module tb_icache -Mdir "$BUILD_DIR" -o Vtb_icache -f build.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$BUILD_DIR/Vtb_icache" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^ALL CHECKS PASSED$" "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1
